/* common/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Memory depth in bytes
`define CPU_MEM_SIZE    256

// Host address, bit 8 selects the start strobe
`define CPU_MAP_ADDR_W  9

// Program starts at byte 4, high nibble
`define CPU_RESET_PC    8'h08

// Stack grows down from the top byte
`define CPU_RESET_SP    8'hFF

`endif

/* common/cpu_pkg.sv */
`include "cpu_defs.svh"
`default_nettype none

package cpu_pkg;

   typedef logic [7:0]                  byte_t;
   typedef logic [`CPU_MAP_ADDR_W-1:0]  map_addr_t;
   typedef logic [2:0]                  rb_sel_t;    // [2] 1 = data_out, 0 = memory

   typedef enum logic [3:0] {
      OP_ADD  = 4'h0, OP_SUB  = 4'h1, OP_MUL  = 4'h2, OP_NAND  = 4'h3,
      OP_SW01 = 4'h4, OP_SW12 = 4'h5, OP_SW23 = 4'h6, OP_BE    = 4'h7,
      OP_POPC = 4'h8, OP_PUSHC = 4'h9, OP_POP = 4'hA, OP_PUSH  = 4'hB,
      OP_LDW  = 4'hC, OP_STW  = 4'hD, OP_REF  = 4'hE, OP_HALT  = 4'hF
   } opcode_e;

   typedef enum logic [3:0] {
      IDLE, LOAD_0, LOAD_1, LOAD_2, LOAD_3, LOAD_4,
      FETCH, DECODE, EXEC_1, EXEC_2, EXEC_3
   } state_e;

   typedef enum logic [3:0] {
      DS_ZERO, DS_ONE, DS_TWO, DS_THREE,
      DS_PC_BYTE,                                     // pc as byte address
      DS_PC_INC, DS_ALU,
      DS_XOR01, DS_XOR12, DS_XOR23,
      DS_R3, DS_R2, DS_SP_INC, DS_SP_DEC,
      DS_MEM, DS_PC
   } data_sel_e;

endpackage

`default_nettype wire

/* hdl/cpu_memory.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"
`default_nettype none

module cpu_memory (
   input  wire logic            clk,
   input  wire cpu_pkg::byte_t  addr,
   input  wire cpu_pkg::byte_t  data_out,
   input  wire logic            mem_we,
   input  wire logic            host_we,
   input  wire cpu_pkg::byte_t  host_addr,
   input  wire cpu_pkg::byte_t  host_wdata,
   output cpu_pkg::byte_t       mem_rdata,
   output cpu_pkg::byte_t       host_rdata
);

   cpu_pkg::byte_t mem [`CPU_MEM_SIZE];

   always_ff @(posedge clk) begin
      if (host_we) begin
         mem[host_addr] <= host_wdata;               // Host has priority
      end else if (mem_we) begin
         mem[addr] <= data_out;
      end
   end

   assign mem_rdata  = mem[addr];
   assign host_rdata = mem[host_addr];

endmodule

`default_nettype wire

/* cpu/cpu_control.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_control (
   input  wire logic                clk,
   input  wire logic                nRst,
   input  wire logic                start,
   input  wire cpu_pkg::opcode_e    ir,
   input  wire logic                z,
   output cpu_pkg::data_sel_e       data_sel,
   output cpu_pkg::rb_sel_t         rb_sel,
   output logic                     rb_we,
   output logic                     pc_we,
   output logic                     sp_we,
   output logic                     ir_we,
   output logic                     ale,
   output logic                     mem_we,
   output logic                     busy
);

   cpu_pkg::state_e state;
   cpu_pkg::state_e next_state;

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         state <= cpu_pkg::IDLE;
      end else if (start) begin
         state <= cpu_pkg::LOAD_0;                   // Soft reset from host
      end else begin
         state <= next_state;
      end
   end

   always_comb begin
      next_state = state;
      case (state)
         cpu_pkg::LOAD_0: next_state = cpu_pkg::LOAD_1;
         cpu_pkg::LOAD_1: next_state = cpu_pkg::LOAD_2;
         cpu_pkg::LOAD_2: next_state = cpu_pkg::LOAD_3;
         cpu_pkg::LOAD_3: next_state = cpu_pkg::LOAD_4;
         cpu_pkg::LOAD_4: next_state = cpu_pkg::FETCH;
         cpu_pkg::FETCH:  next_state = cpu_pkg::DECODE;
         cpu_pkg::DECODE: next_state = cpu_pkg::EXEC_1;
         cpu_pkg::EXEC_1: begin
            case (ir)
               cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_MUL,
               cpu_pkg::OP_NAND, cpu_pkg::OP_BE: next_state = cpu_pkg::FETCH;
               cpu_pkg::OP_HALT:                 next_state = cpu_pkg::IDLE;
               default:                          next_state = cpu_pkg::EXEC_2;
            endcase
         end
         cpu_pkg::EXEC_2: begin
            case (ir)
               cpu_pkg::OP_SW01, cpu_pkg::OP_SW12, cpu_pkg::OP_SW23,
               cpu_pkg::OP_PUSH, cpu_pkg::OP_PUSHC: next_state = cpu_pkg::EXEC_3;
               default:                             next_state = cpu_pkg::FETCH;
            endcase
         end
         cpu_pkg::EXEC_3: next_state = cpu_pkg::FETCH;
         default:         next_state = cpu_pkg::IDLE;
      endcase
   end

   always_comb begin
      data_sel = cpu_pkg::DS_ZERO;
      rb_sel   = 3'b100;
      rb_we    = 1'b0;
      pc_we    = 1'b0;
      sp_we    = 1'b0;
      ir_we    = 1'b0;
      ale      = 1'b0;
      mem_we   = 1'b0;
      case (state)
         cpu_pkg::LOAD_0: ale = 1'b1;                // Point at byte 0
         cpu_pkg::LOAD_1: begin
            data_sel = cpu_pkg::DS_ONE;
            rb_sel   = 3'b000;
            rb_we    = 1'b1;
            ale      = 1'b1;
         end
         cpu_pkg::LOAD_2: begin
            data_sel = cpu_pkg::DS_TWO;
            rb_sel   = 3'b001;
            rb_we    = 1'b1;
            ale      = 1'b1;
         end
         cpu_pkg::LOAD_3: begin
            data_sel = cpu_pkg::DS_THREE;
            rb_sel   = 3'b010;
            rb_we    = 1'b1;
            ale      = 1'b1;
         end
         cpu_pkg::LOAD_4: begin
            data_sel = cpu_pkg::DS_PC_BYTE;
            rb_sel   = 3'b011;
            rb_we    = 1'b1;
            ale      = 1'b1;
         end
         cpu_pkg::FETCH: begin
            data_sel = cpu_pkg::DS_PC_BYTE;
            ale      = 1'b1;
         end
         cpu_pkg::DECODE: begin
            data_sel = cpu_pkg::DS_PC_INC;
            ir_we    = 1'b1;
            pc_we    = 1'b1;
         end
         cpu_pkg::EXEC_1: begin
            case (ir)
               cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_MUL, cpu_pkg::OP_NAND: begin
                  data_sel = cpu_pkg::DS_ALU;
                  rb_we    = 1'b1;
               end
               cpu_pkg::OP_SW01: begin
                  data_sel = cpu_pkg::DS_XOR01;
                  rb_we    = 1'b1;
               end
               cpu_pkg::OP_SW12: begin
                  data_sel = cpu_pkg::DS_XOR12;
                  rb_sel   = 3'b101;
                  rb_we    = 1'b1;
               end
               cpu_pkg::OP_SW23: begin
                  data_sel = cpu_pkg::DS_XOR23;
                  rb_sel   = 3'b110;
                  rb_we    = 1'b1;
               end
               cpu_pkg::OP_BE: begin
                  data_sel = cpu_pkg::DS_R3;
                  pc_we    = z;                      // Taken only if r1 == r2
               end
               cpu_pkg::OP_POP, cpu_pkg::OP_POPC: begin
                  data_sel = cpu_pkg::DS_SP_INC;
                  sp_we    = 1'b1;
                  ale      = 1'b1;
               end
               cpu_pkg::OP_PUSH, cpu_pkg::OP_PUSHC: begin
                  data_sel = cpu_pkg::DS_SP_DEC;
                  sp_we    = 1'b1;
               end
               cpu_pkg::OP_LDW, cpu_pkg::OP_STW: begin
                  data_sel = cpu_pkg::DS_R3;
                  ale      = 1'b1;
               end
               cpu_pkg::OP_REF: ale = 1'b1;
               default: ;                            // HALT
            endcase
         end
         cpu_pkg::EXEC_2: begin
            case (ir)
               cpu_pkg::OP_SW01: begin
                  data_sel = cpu_pkg::DS_XOR01;
                  rb_sel   = 3'b101;
                  rb_we    = 1'b1;
               end
               cpu_pkg::OP_SW12: begin
                  data_sel = cpu_pkg::DS_XOR12;
                  rb_sel   = 3'b110;
                  rb_we    = 1'b1;
               end
               cpu_pkg::OP_SW23: begin
                  data_sel = cpu_pkg::DS_XOR23;
                  rb_sel   = 3'b111;
                  rb_we    = 1'b1;
               end
               cpu_pkg::OP_POP, cpu_pkg::OP_LDW: begin
                  data_sel = cpu_pkg::DS_MEM;
                  rb_sel   = 3'b010;
                  rb_we    = 1'b1;
               end
               cpu_pkg::OP_POPC: begin
                  data_sel = cpu_pkg::DS_MEM;
                  pc_we    = 1'b1;
               end
               cpu_pkg::OP_PUSH, cpu_pkg::OP_PUSHC: begin
                  data_sel = cpu_pkg::DS_SP_INC;     // Slot above the new sp
                  ale      = 1'b1;
               end
               cpu_pkg::OP_STW: begin
                  data_sel = cpu_pkg::DS_R2;
                  mem_we   = 1'b1;
               end
               cpu_pkg::OP_REF: begin
                  rb_sel   = 3'b000;
                  rb_we    = 1'b1;
               end
               default: ;
            endcase
         end
         cpu_pkg::EXEC_3: begin
            case (ir)
               cpu_pkg::OP_SW01: begin
                  data_sel = cpu_pkg::DS_XOR01;
                  rb_we    = 1'b1;
               end
               cpu_pkg::OP_SW12: begin
                  data_sel = cpu_pkg::DS_XOR12;
                  rb_sel   = 3'b101;
                  rb_we    = 1'b1;
               end
               cpu_pkg::OP_SW23: begin
                  data_sel = cpu_pkg::DS_XOR23;
                  rb_sel   = 3'b110;
                  rb_we    = 1'b1;
               end
               cpu_pkg::OP_PUSH: begin
                  data_sel = cpu_pkg::DS_R2;
                  mem_we   = 1'b1;
               end
               cpu_pkg::OP_PUSHC: begin
                  data_sel = cpu_pkg::DS_PC;         // Already the next instruction
                  mem_we   = 1'b1;
               end
               default: ;
            endcase
         end
         default: ;
      endcase
   end

   assign busy = (state != cpu_pkg::IDLE);

endmodule

`default_nettype wire

/* cpu/cpu_datapath.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"
`default_nettype none

module cpu_datapath (
   input  wire logic                clk,
   input  wire logic                nRst,
   input  wire logic                start,
   input  wire cpu_pkg::data_sel_e  data_sel,
   input  wire cpu_pkg::rb_sel_t    rb_sel,
   input  wire logic                rb_we,
   input  wire logic                pc_we,
   input  wire logic                sp_we,
   input  wire logic                ir_we,
   input  wire logic                ale,
   input  wire cpu_pkg::byte_t      mem_rdata,
   output cpu_pkg::opcode_e         ir,
   output logic                     z,
   output cpu_pkg::byte_t           addr,
   output cpu_pkg::byte_t           data_out
);

   cpu_pkg::byte_t r0, r1, r2, r3;
   cpu_pkg::byte_t pc;                               // Nibble address
   cpu_pkg::byte_t sp;
   cpu_pkg::byte_t alu_res;
   cpu_pkg::byte_t rb_data;

   always_comb begin
      case (ir)
         cpu_pkg::OP_SUB:  alu_res = r1 - r2;
         cpu_pkg::OP_MUL:  alu_res = r1 * r2;        // Low byte only
         cpu_pkg::OP_NAND: alu_res = ~(r1 & r2);
         default:          alu_res = r1 + r2;
      endcase
   end

   always_comb begin
      case (data_sel)
         cpu_pkg::DS_ZERO:    data_out = 8'h00;
         cpu_pkg::DS_ONE:     data_out = 8'h01;
         cpu_pkg::DS_TWO:     data_out = 8'h02;
         cpu_pkg::DS_THREE:   data_out = 8'h03;
         cpu_pkg::DS_PC_BYTE: data_out = {1'b0, pc[7:1]};
         cpu_pkg::DS_PC_INC:  data_out = pc + 8'd1;
         cpu_pkg::DS_ALU:     data_out = alu_res;
         cpu_pkg::DS_XOR01:   data_out = r0 ^ r1;
         cpu_pkg::DS_XOR12:   data_out = r1 ^ r2;
         cpu_pkg::DS_XOR23:   data_out = r2 ^ r3;
         cpu_pkg::DS_R3:      data_out = r3;
         cpu_pkg::DS_R2:      data_out = r2;
         cpu_pkg::DS_SP_INC:  data_out = sp + 8'd1;
         cpu_pkg::DS_SP_DEC:  data_out = sp - 8'd1;
         cpu_pkg::DS_MEM:     data_out = mem_rdata;
         default:             data_out = pc;
      endcase
   end

   assign rb_data = rb_sel[2] ? data_out : mem_rdata;
   assign z       = (r1 == r2);

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         r0   <= 8'h00;
         r1   <= 8'h00;
         r2   <= 8'h00;
         r3   <= 8'h00;
         pc   <= `CPU_RESET_PC;
         sp   <= `CPU_RESET_SP;
         ir   <= cpu_pkg::OP_ADD;
         addr <= 8'h00;
      end else if (start) begin
         r0   <= 8'h00;
         r1   <= 8'h00;
         r2   <= 8'h00;
         r3   <= 8'h00;
         pc   <= `CPU_RESET_PC;
         sp   <= `CPU_RESET_SP;
         ir   <= cpu_pkg::OP_ADD;
         addr <= 8'h00;
      end else begin
         if (pc_we) pc <= data_out;
         if (sp_we) sp <= data_out;
         if (ale)   addr <= data_out;
         if (ir_we) begin                            // Odd pc takes the low nibble
            ir <= cpu_pkg::opcode_e'(pc[0] ? mem_rdata[3:0] : mem_rdata[7:4]);
         end
         if (rb_we) begin
            case (rb_sel[1:0])
               2'd0:    r0 <= rb_data;
               2'd1:    r1 <= rb_data;
               2'd2:    r2 <= rb_data;
               default: r3 <= rb_data;
            endcase
         end
      end
   end

endmodule

`default_nettype wire

/* hdl/nibble_cpu.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"
`default_nettype none

module nibble_cpu (
   input  wire logic                clk,
   input  wire logic                nRst,
   input  wire logic                mem_map_load,
   input  wire cpu_pkg::map_addr_t  mem_map_address,
   input  wire cpu_pkg::byte_t      mem_map_in,
   output cpu_pkg::byte_t           mem_map_out,
   output logic                     busy
);

   logic               start;
   logic               host_we;
   logic               map_hi;
   cpu_pkg::data_sel_e data_sel;
   cpu_pkg::rb_sel_t   rb_sel;
   logic               rb_we;
   logic               pc_we;
   logic               sp_we;
   logic               ir_we;
   logic               ale;
   logic               mem_we;
   cpu_pkg::opcode_e   ir;
   logic               z;
   cpu_pkg::byte_t     addr;
   cpu_pkg::byte_t     data_out;
   cpu_pkg::byte_t     mem_rdata;
   cpu_pkg::byte_t     host_rdata;

   assign map_hi      = mem_map_address[`CPU_MAP_ADDR_W-1];
   assign start       = mem_map_load & map_hi;       // Write above memory starts the core
   assign host_we     = mem_map_load & ~map_hi;
   assign mem_map_out = map_hi ? 8'h00 : host_rdata;

   cpu_control i_cpu_control (
      .clk      (clk),
      .nRst     (nRst),
      .start    (start),
      .ir       (ir),
      .z        (z),
      .data_sel (data_sel),
      .rb_sel   (rb_sel),
      .rb_we    (rb_we),
      .pc_we    (pc_we),
      .sp_we    (sp_we),
      .ir_we    (ir_we),
      .ale      (ale),
      .mem_we   (mem_we),
      .busy     (busy)
   );

   cpu_datapath i_cpu_datapath (
      .clk       (clk),
      .nRst      (nRst),
      .start     (start),
      .data_sel  (data_sel),
      .rb_sel    (rb_sel),
      .rb_we     (rb_we),
      .pc_we     (pc_we),
      .sp_we     (sp_we),
      .ir_we     (ir_we),
      .ale       (ale),
      .mem_rdata (mem_rdata),
      .ir        (ir),
      .z         (z),
      .addr      (addr),
      .data_out  (data_out)
   );

   cpu_memory i_cpu_memory (
      .clk        (clk),
      .addr       (addr),
      .data_out   (data_out),
      .mem_we     (mem_we),
      .host_we    (host_we),
      .host_addr  (mem_map_address[7:0]),
      .host_wdata (mem_map_in),
      .mem_rdata  (mem_rdata),
      .host_rdata (host_rdata)
   );

endmodule

`default_nettype wire

/* tb/nibble_cpu_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module nibble_cpu_checker (
   input wire logic clk,
   input wire logic nRst,
   input wire logic rb_we,
   input wire logic pc_we,
   input wire logic sp_we,
   input wire logic ir_we,
   input wire logic ale,
   input wire logic mem_we,
   input wire logic busy
);

   logic strobes;

   assign strobes = rb_we | pc_we | sp_we | ir_we | ale | mem_we;

   ale_no_write: assert property (@(posedge clk) disable iff (!nRst) !(ale && mem_we))
      else $error("ale and mem_we high in the same cycle");

   idle_quiet: assert property (@(posedge clk) disable iff (!nRst) !busy |-> !strobes)
      else $error("strobe active while the core is idle");

   // First cycle out of hard reset
   reset_idle: assert property (@(posedge clk) $rose(nRst) |-> !busy)
      else $error("busy high right after reset release");

endmodule

bind cpu_control nibble_cpu_checker i_nibble_cpu_checker (
   .clk    (clk),
   .nRst   (nRst),
   .rb_we  (rb_we),
   .pc_we  (pc_we),
   .sp_we  (sp_we),
   .ir_we  (ir_we),
   .ale    (ale),
   .mem_we (mem_we),
   .busy   (busy)
);

`default_nettype wire

/* tb/tb_nibble_cpu.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"
`default_nettype none

module tb_nibble_cpu;

   localparam int RUNS        = 11;
   localparam int INSTR_COUNT = 59;                  // Executed over all runs
   localparam int HOST_OPS    = 160;
   localparam int MAX_CYCLES  = 10 + RUNS * 7 + INSTR_COUNT * 5 + HOST_OPS * 2 + 200;
   localparam cpu_pkg::map_addr_t START_ADDR = {1'b1, {(`CPU_MAP_ADDR_W-1){1'b0}}};

   logic                clk             = 1'b0;
   logic                nRst            = 1'b0;
   logic                mem_map_load    = 1'b0;
   cpu_pkg::map_addr_t  mem_map_address = '0;
   cpu_pkg::byte_t      mem_map_in      = '0;
   cpu_pkg::byte_t      mem_map_out;
   logic                busy;

   int seed;
   int errors;
   int checks;
   int cycle_count = 0;

   nibble_cpu i_nibble_cpu (
      .clk             (clk),
      .nRst            (nRst),
      .mem_map_load    (mem_map_load),
      .mem_map_address (mem_map_address),
      .mem_map_in      (mem_map_in),
      .mem_map_out     (mem_map_out),
      .busy            (busy)
   );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= MAX_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         $display("TEST FAILED");
         $finish;
      end
   end

   task automatic check_byte(input string name, input cpu_pkg::byte_t exp,
                             input cpu_pkg::byte_t act);
      checks++;
      if (act !== exp) begin
         $display("Mismatch %s: expected %02h, actual %02h", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         $display("Mismatch %s: expected %0b, actual %0b", name, exp, act);
         errors++;
      end
   endtask

   task automatic write_byte(input cpu_pkg::byte_t a, input cpu_pkg::byte_t d);
      @(posedge clk);
      mem_map_load    <= 1'b1;
      mem_map_address <= {1'b0, a};
      mem_map_in      <= d;
   endtask

   task automatic read_byte(input cpu_pkg::map_addr_t a, output cpu_pkg::byte_t d);
      @(posedge clk);
      mem_map_load    <= 1'b0;
      mem_map_address <= a;
      @(posedge clk);
      d = mem_map_out;
   endtask

   task automatic expect_mem(input string name, input cpu_pkg::byte_t a,
                             input cpu_pkg::byte_t exp);
      cpu_pkg::byte_t d;
      read_byte({1'b0, a}, d);
      check_byte(name, exp, d);
   endtask

   // Register bytes 0 to 3, program nibbles from byte 4 high nibble first
   task automatic load_image(input cpu_pkg::byte_t v0, v1, v2, v3, input logic [31:0] prog);
      int i;
      write_byte(8'd0, v0);
      write_byte(8'd1, v1);
      write_byte(8'd2, v2);
      write_byte(8'd3, v3);
      for (i = 0; i < 4; i++) begin
         write_byte(cpu_pkg::byte_t'(4 + i), prog[31 - 8 * i -: 8]);
      end
   endtask

   task automatic run_program(input string name, input int n_instr);
      int limit;
      int n;
      limit = 5 + 5 * n_instr + 8;
      n     = 0;
      @(posedge clk);
      mem_map_load    <= 1'b1;
      mem_map_address <= START_ADDR;
      @(posedge clk);
      mem_map_load    <= 1'b0;
      @(posedge clk);
      check_bit({name, " busy"}, 1'b1, busy);
      while (busy && n < limit) begin
         @(posedge clk);
         n++;
      end
      if (busy) begin
         $display("%s: busy still high after %0d cycles", name, limit);
         errors++;
      end
   endtask

   function automatic cpu_pkg::byte_t expected_alu(input cpu_pkg::opcode_e op,
                                                   input cpu_pkg::byte_t a,
                                                   input cpu_pkg::byte_t b);
      logic [15:0] prod;
      prod = 16'(a) * 16'(b);
      case (op)
         cpu_pkg::OP_SUB:  return a - b;
         cpu_pkg::OP_MUL:  return prod[7:0];
         cpu_pkg::OP_NAND: return ~(a & b);
         default:          return a + b;
      endcase
   endfunction

   task automatic alu_ops();
      cpu_pkg::opcode_e ops [4];
      cpu_pkg::opcode_e op;
      cpu_pkg::byte_t   a;
      cpu_pkg::byte_t   b;
      cpu_pkg::byte_t   c;
      ops = '{cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_MUL, cpu_pkg::OP_NAND};
      foreach (ops[i]) begin
         op = ops[i];
         a  = cpu_pkg::byte_t'($random(seed));
         b  = cpu_pkg::byte_t'($random(seed));
         c  = cpu_pkg::byte_t'($random(seed));
         write_byte(8'h40, 8'h00);
         load_image(c, a, b, 8'h40, {op, 28'h45DFFFF});   // op SW01 SW12 STW HALT
         run_program(op.name(), 5);
         expect_mem(op.name(), 8'h40, expected_alu(op, a, b));
      end
   endtask

   task automatic register_swaps();
      write_byte(8'h70, 8'h00);
      write_byte(8'h71, 8'h00);
      load_image(8'h70, 8'h2B, 8'hD4, 8'h71, 32'h45D6DFFF);   // SW01 SW12 STW SW23 STW HALT
      run_program("swaps", 6);
      expect_mem("swap r0 into r2", 8'h71, 8'h70);
      expect_mem("swap r3 into r2", 8'h70, 8'h71);
   endtask

   task automatic branch_equal();
      write_byte(8'd10, 8'hEE);                      // Marker left alone when taken
      load_image(8'h00, 8'h5A, 8'h5A, 8'd10, 32'h7DFFFFFF);   // BE STW HALT
      run_program("be taken", 2);
      expect_mem("be taken", 8'd10, 8'hEE);
      write_byte(8'd10, 8'hEE);
      load_image(8'h00, 8'h5A, 8'h3C, 8'd10, 32'h7DFFFFFF);
      run_program("be not taken", 3);
      expect_mem("be not taken", 8'd10, 8'h3C);
   endtask

   task automatic stack_ops();
      write_byte(8'h80, 8'h00);
      load_image(8'h00, 8'h21, 8'hC4, 8'h80, 32'hB5ADFFFF);   // PUSH SW12 POP STW HALT
      run_program("push pop", 5);
      expect_mem("push slot", 8'hFF, 8'hC4);
      expect_mem("pop r2", 8'h80, 8'hC4);
      // Second pass through BE is taken after SW01 makes r1 equal r2
      write_byte(8'd13, 8'h00);
      load_image(8'h3C, 8'h5A, 8'h3C, 8'd13, 32'h9748FDFF);   // PUSHC BE SW01 POPC HALT STW HALT
      run_program("pushc popc", 7);
      expect_mem("pushc slot", 8'hFF, 8'h09);
      expect_mem("popc return", 8'd13, 8'h3C);
   endtask

   task automatic host_port();
      cpu_pkg::byte_t d;
      write_byte(8'h90, 8'hA5);
      write_byte(8'hFE, 8'h00);
      write_byte(8'hFF, 8'h00);
      load_image(8'h11, 8'h22, 8'h33, 8'h90, 32'hCB0E45BF);   // LDW PUSH ADD REF SW01 SW12 PUSH HALT
      run_program("ldw ref", 8);
      expect_mem("ldw", 8'hFF, 8'hA5);
      expect_mem("ref", 8'hFE, 8'h11);
      read_byte(START_ADDR, d);
      check_byte("high read 100", 8'h00, d);
      read_byte(9'h190, d);
      check_byte("high read 190", 8'h00, d);
      read_byte(9'h1FF, d);
      check_byte("high read 1ff", 8'h00, d);
      write_byte(8'h00, 8'h66);                      // New r0 for the restart
      write_byte(8'hFE, 8'h00);
      write_byte(8'hFF, 8'h00);
      run_program("restart", 8);
      expect_mem("restart r0", 8'hFE, 8'h66);
      expect_mem("restart ldw", 8'hFF, 8'hA5);
   endtask

   initial begin
      seed   = 32'h2695;
      errors = 0;
      checks = 0;
      repeat (10) @(posedge clk);
      nRst <= 1'b1;
      @(posedge clk);
      check_bit("idle after reset", 1'b0, busy);
      alu_ops();
      register_swaps();
      branch_equal();
      stack_ops();
      host_port();
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* sources.f */
+incdir+common
common/cpu_pkg.sv
hdl/cpu_memory.sv
cpu/cpu_control.sv
cpu/cpu_datapath.sv
hdl/nibble_cpu.sv
tb/nibble_cpu_checker.sv
tb/tb_nibble_cpu.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_nibble_cpu
FILELIST   ?= sources.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

SRCS := $(shell grep -v '^+' $(FILELIST)) common/cpu_defs.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
